/* project.f */
source/mem_bus_pkg.sv
source/arb_pkg.sv
source/mem_bus_if.sv
source/mem_arbiter.sv
source/mem_backend.sv
source/mem_subsystem.sv
tb/tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Mdir obj_dir \
    -f project.f --top-module tb_mem_subsystem -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

/* tb/tb_mem_subsystem.sv */
// Shadow memory decodes the same low address bits as the back end; contention runs on cleared memory
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int latency         = mem_bus_pkg::wait_states + 3;
    localparam int total_transfers = 46;
    localparam int timeout_cycles  = 40 * total_transfers * latency;
    // One transfer of the other side plus its own, with margin
    localparam int max_wait        = 3 * latency;

    logic                               clk;
    logic                               reset;
    logic [mem_bus_pkg::addr_width:1]   cpu_addr;
    logic [mem_bus_pkg::data_width-1:0] cpu_wdata;
    logic                               cpu_access;
    logic                               cpu_wr_en;
    logic [mem_bus_pkg::sel_width-1:0]  cpu_bytesel;
    logic [mem_bus_pkg::data_width-1:0] cpu_rdata;
    logic                               cpu_ack;
    logic [mem_bus_pkg::addr_width:1]   video_addr;
    logic [mem_bus_pkg::data_width-1:0] video_wdata;
    logic                               video_access;
    logic                               video_wr_en;
    logic [mem_bus_pkg::sel_width-1:0]  video_bytesel;
    logic [mem_bus_pkg::data_width-1:0] video_rdata;
    logic                               video_ack;
    logic                               video_owns_bus;

    logic [15:0]                        lfsr;
    logic [mem_bus_pkg::data_width-1:0] shadow [mem_bus_pkg::mem_words];
    logic [31:0]                        written [$];
    arb_pkg::requester_t                ack_order [$];
    string                              test_name;
    int                                 errors;
    int                                 mark;
    int                                 tests_passed;
    int                                 tests_failed;
    int                                 cpu_wait;
    int                                 video_wait;
    int                                 cycle_count;
    bit                                 record_order;
    bit                                 check_latency;

    mem_subsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    // Fibonacci LFSR, taps 16 15 13 4
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        mark      = errors;
    endtask

    task automatic end_test();
        if (errors == mark) tests_passed++;
        else tests_failed++;
        $display("Test %s: %s", test_name, (errors == mark) ? "pass" : "fail");
    endtask

    // One complete access/ack handshake; the shadow memory predicts read data
    task automatic transfer(input arb_pkg::requester_t who, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic wr_en,
                            input logic [mem_bus_pkg::sel_width-1:0] sel);
        logic [mem_bus_pkg::data_width-1:0]      rdata;
        logic [mem_bus_pkg::mem_index_width-1:0] idx;
        int                                      cycles;
        idx = addr[mem_bus_pkg::mem_index_width-1:0];
        @(posedge clk);
        if (who == arb_pkg::video) begin
            video_addr    <= addr[mem_bus_pkg::addr_width-1:0];
            video_wdata   <= wdata[mem_bus_pkg::data_width-1:0];
            video_wr_en   <= wr_en;
            video_bytesel <= sel;
            video_access  <= 1'b1;
        end else begin
            cpu_addr    <= addr[mem_bus_pkg::addr_width-1:0];
            cpu_wdata   <= wdata[mem_bus_pkg::data_width-1:0];
            cpu_wr_en   <= wr_en;
            cpu_bytesel <= sel;
            cpu_access  <= 1'b1;
        end
        // Idle arbiter samples the request one edge after it is driven
        cycles = -1;
        @(negedge clk);
        while (!((who == arb_pkg::video) ? video_ack : cpu_ack)) begin
            @(negedge clk);
            cycles++;
        end
        rdata = (who == arb_pkg::video) ? video_rdata : cpu_rdata;
        if (check_latency) check_value("latency", latency, cycles);
        if (wr_en) begin
            for (int lane = 0; lane < mem_bus_pkg::sel_width; lane++) begin
                if (sel[lane]) shadow[idx][lane*8 +: 8] = wdata[lane*8 +: 8];
            end
        end else begin
            check_value("read data", int'(shadow[idx]), int'(rdata));
        end
        // Drop access in the cycle after ack
        @(posedge clk);
        if (who == arb_pkg::video) video_access <= 1'b0;
        else cpu_access <= 1'b0;
    endtask

    // ====================
    // Handshake assertions
    // ====================

    assert property (@(posedge clk) disable iff (reset)
                     !($past(cpu_ack) && cpu_ack) && !($past(video_ack) && video_ack)) else begin
        $display("Error: an ack stayed high for more than one cycle");
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset)
                     (cpu_ack || cpu_rdata == '0) && (video_ack || video_rdata == '0)) else begin
        $display("Error: rdata was not zero outside its ack cycle");
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset) !(cpu_ack && video_ack)) else begin
        $display("Error: both requesters saw ack in the same cycle");
        errors++;
    end

    // Display hint follows a pending video request unless the CPU holds the bus
    assert property (@(posedge clk) disable iff (reset)
                     video_access && (uut.u_arbiter.state == arb_pkg::idle ||
                     uut.u_arbiter.state == arb_pkg::serving_video) |-> video_owns_bus) else begin
        $display("Error: video_owns_bus low while a video request was pending");
        errors++;
    end

    // Held requests must be answered; also logs ack order for the contention test
    always @(negedge clk) begin
        cpu_wait   = (cpu_access && !cpu_ack) ? cpu_wait + 1 : 0;
        video_wait = (video_access && !video_ack) ? video_wait + 1 : 0;
        assert (cpu_wait != max_wait && video_wait != max_wait) else begin
            $display("Error: a held request got no ack within %0d cycles", max_wait);
            errors++;
        end
        if (record_order && cpu_ack) ack_order.push_back(arb_pkg::cpu);
        if (record_order && video_ack) ack_order.push_back(arb_pkg::video);
    end

    // Watchdog sized from the number of transfers
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================

    initial begin
        logic [31:0] a;
        reset         = 1'b1;
        cpu_addr      = '0;
        cpu_wdata     = '0;
        cpu_access    = 1'b0;
        cpu_wr_en     = 1'b0;
        cpu_bytesel   = '0;
        video_addr    = '0;
        video_wdata   = '0;
        video_access  = 1'b0;
        video_wr_en   = 1'b0;
        video_bytesel = '0;
        lfsr          = 16'd59169;
        record_order  = 1'b0;
        check_latency = 1'b0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Outputs stay quiet until the first request
        begin_test("reset_idle");
        repeat (4) begin
            @(negedge clk);
            check_value("acks and owner", 0, int'({cpu_ack, video_ack, video_owns_bus}));
            check_value("rdata", 0, int'(cpu_rdata | video_rdata));
        end
        end_test();

        // Last served starts as video, so the CPU wins the first tie
        begin_test("contention");
        record_order = 1'b1;
        fork
            repeat (6) transfer(arb_pkg::cpu, random_bits(mem_bus_pkg::addr_width), 0, 1'b0, 2'b11);
            repeat (6) transfer(arb_pkg::video, random_bits(mem_bus_pkg::addr_width), 0, 1'b0, 2'b11);
        join
        record_order = 1'b0;
        check_value("ack count", 12, ack_order.size());
        foreach (ack_order[i]) begin
            check_value("winner", (i % 2 == 0) ? int'(arb_pkg::cpu) : int'(arb_pkg::video),
                        int'(ack_order[i]));
        end
        end_test();

        // Full-word CPU writes, then read-back
        begin_test("single_port");
        check_latency = 1'b1;
        repeat (8) begin
            a = random_bits(mem_bus_pkg::addr_width);
            written.push_back(a);
            transfer(arb_pkg::cpu, a, random_bits(mem_bus_pkg::data_width), 1'b1, 2'b11);
        end
        foreach (written[i]) transfer(arb_pkg::cpu, written[i], 0, 1'b0, 2'b11);
        end_test();

        // Single-lane video writes, checked through the CPU port and the video port
        begin_test("byte_lanes");
        for (int i = 0; i < 6; i++) begin
            transfer(arb_pkg::video, written[i], random_bits(mem_bus_pkg::data_width), 1'b1,
                     (random_bits(1) != 0) ? 2'b10 : 2'b01);
        end
        for (int i = 0; i < 6; i++) transfer(arb_pkg::cpu, written[i], 0, 1'b0, 2'b11);
        for (int i = 0; i < 6; i++) transfer(arb_pkg::video, written[i], 0, 1'b0, 2'b11);
        end_test();

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* source/mem_subsystem.sv */
// Two requesters sharing one memory; each requester must hold its access fields stable until ack
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                               clk,
    input  logic                               reset,

    // CPU requester
    input  logic [mem_bus_pkg::addr_width:1]   cpu_addr,
    input  logic [mem_bus_pkg::data_width-1:0] cpu_wdata,
    input  logic                               cpu_access,
    input  logic                               cpu_wr_en,
    input  logic [mem_bus_pkg::sel_width-1:0]  cpu_bytesel,
    output logic [mem_bus_pkg::data_width-1:0] cpu_rdata,
    output logic                               cpu_ack,

    // Video scanout requester
    input  logic [mem_bus_pkg::addr_width:1]   video_addr,
    input  logic [mem_bus_pkg::data_width-1:0] video_wdata,
    input  logic                               video_access,
    input  logic                               video_wr_en,
    input  logic [mem_bus_pkg::sel_width-1:0]  video_bytesel,
    output logic [mem_bus_pkg::data_width-1:0] video_rdata,
    output logic                               video_ack,

    output logic                               video_owns_bus
);

    mem_bus_if cpu_bus ();
    mem_bus_if video_bus ();
    mem_bus_if mem_bus ();

    // ====================
    // Requester ports
    // ====================

    assign cpu_bus.addr    = cpu_addr;
    assign cpu_bus.wdata   = cpu_wdata;
    assign cpu_bus.access  = cpu_access;
    assign cpu_bus.wr_en   = cpu_wr_en;
    assign cpu_bus.bytesel = cpu_bytesel;
    assign cpu_rdata       = cpu_bus.rdata;
    assign cpu_ack         = cpu_bus.ack;

    assign video_bus.addr    = video_addr;
    assign video_bus.wdata   = video_wdata;
    assign video_bus.access  = video_access;
    assign video_bus.wr_en   = video_wr_en;
    assign video_bus.bytesel = video_bytesel;
    assign video_rdata       = video_bus.rdata;
    assign video_ack         = video_bus.ack;

    // ====================
    // Arbiter and memory
    // ====================

    mem_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .cpu            (cpu_bus.responder),
        .video          (video_bus.responder),
        .mem            (mem_bus.requester),
        .video_owns_bus (video_owns_bus)
    );

    mem_backend u_backend (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus.responder)
    );

endmodule

/* source/mem_backend.sv */
// Behavioural memory with fixed wait states; only the low address bits are decoded so upper space aliases
`timescale 1ns/1ps

module mem_backend (
    input  logic         clk,
    input  logic         reset,
    mem_bus_if.responder bus
);

    logic [mem_bus_pkg::data_width-1:0] mem [mem_bus_pkg::mem_words];

    logic [mem_bus_pkg::mem_index_width-1:0] index;

    // Wait-state sequencing
    logic                   busy;
    logic                   ack_q;
    mem_bus_pkg::wait_cnt_t cnt;

    // Low word-address bits pick the array entry
    assign index = bus.addr[mem_bus_pkg::mem_index_width:1];

    // ====================
    // Access sequencing
    // ====================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            ack_q <= 1'b0;
            cnt   <= '0;
            // Array starts cleared
            for (int i = 0; i < mem_bus_pkg::mem_words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // Ack is a single-cycle pulse
            ack_q <= 1'b0;
            if (busy) begin
                if (cnt == mem_bus_pkg::wait_cnt_t'(mem_bus_pkg::wait_states)) begin
                    busy  <= 1'b0;
                    ack_q <= 1'b1;
                    // Write only the selected byte lanes
                    if (bus.wr_en) begin
                        for (int lane = 0; lane < mem_bus_pkg::sel_width; lane++) begin
                            if (bus.bytesel[lane]) begin
                                mem[index][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
                            end
                        end
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (bus.access && !ack_q) begin
                // Access still high in the ack cycle is ignored
                busy <= 1'b1;
                cnt  <= '0;
            end
        end
    end

    // ====================
    // Response
    // ====================

    assign bus.ack = ack_q;

    // Read data only during the ack cycle of a read
    assign bus.rdata = (ack_q && !bus.wr_en) ? mem[index] : '0;

endmodule

/* source/mem_arbiter.sv */
// Round-robin between two requesters; each requester sees ack one cycle after the memory ack
`timescale 1ns/1ps

module mem_arbiter (
    input  logic         clk,
    input  logic         reset,
    mem_bus_if.responder cpu,
    mem_bus_if.responder video,
    mem_bus_if.requester mem,
    output logic         video_owns_bus
);

    arb_pkg::arb_state_t state;
    arb_pkg::requester_t last_served;
    arb_pkg::requester_t winner;
    arb_pkg::requester_t grant;

    logic cpu_req;
    logic video_req;
    logic any_req;

    // Registered responses back to each requester
    logic                               cpu_ack_q;
    logic                               video_ack_q;
    logic [mem_bus_pkg::data_width-1:0] cpu_rdata_q;
    logic [mem_bus_pkg::data_width-1:0] video_rdata_q;

    // ====================
    // Winner selection
    // ====================

    // A requester is still holding access during its own ack cycle
    // so it is masked until it has seen ack
    assign cpu_req   = cpu.access && !cpu_ack_q;
    assign video_req = video.access && !video_ack_q;
    assign any_req   = cpu_req || video_req;

    always_comb begin
        if (cpu_req && video_req) begin
            // Tie goes to the side not served last
            winner = (last_served == arb_pkg::cpu) ? arb_pkg::video : arb_pkg::cpu;
        end else if (video_req) begin
            winner = arb_pkg::video;
        end else begin
            winner = arb_pkg::cpu;
        end
    end

    // ====================
    // Grant FSM
    // ====================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= arb_pkg::idle;
            // CPU wins the first tie
            last_served <= arb_pkg::video;
        end else begin
            case (state)
                arb_pkg::idle: begin
                    if (any_req) begin
                        state <= (winner == arb_pkg::video) ? arb_pkg::serving_video
                                                            : arb_pkg::serving_cpu;
                    end
                end
                arb_pkg::serving_cpu: begin
                    if (mem.ack) begin
                        state       <= arb_pkg::idle;
                        last_served <= arb_pkg::cpu;
                    end
                end
                arb_pkg::serving_video: begin
                    if (mem.ack) begin
                        state       <= arb_pkg::idle;
                        last_served <= arb_pkg::video;
                    end
                end
                default: state <= arb_pkg::idle;
            endcase
        end
    end

    // ====================
    // Memory side steering
    // ====================

    assign grant = (state == arb_pkg::serving_video) ? arb_pkg::video : arb_pkg::cpu;

    // Access drops in the cycle after the memory ack
    assign mem.access  = (state != arb_pkg::idle);
    assign mem.addr    = (grant == arb_pkg::video) ? video.addr : cpu.addr;
    assign mem.wdata   = (grant == arb_pkg::video) ? video.wdata : cpu.wdata;
    assign mem.wr_en   = (grant == arb_pkg::video) ? video.wr_en : cpu.wr_en;
    assign mem.bytesel = (grant == arb_pkg::video) ? video.bytesel : cpu.bytesel;

    // ====================
    // Response registers
    // ====================

    // Data is captured with the ack so both reach the requester together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cpu_ack_q     <= 1'b0;
            video_ack_q   <= 1'b0;
            cpu_rdata_q   <= '0;
            video_rdata_q <= '0;
        end else begin
            cpu_ack_q     <= (state == arb_pkg::serving_cpu) && mem.ack;
            video_ack_q   <= (state == arb_pkg::serving_video) && mem.ack;
            cpu_rdata_q   <= ((state == arb_pkg::serving_cpu) && mem.ack) ? mem.rdata : '0;
            video_rdata_q <= ((state == arb_pkg::serving_video) && mem.ack) ? mem.rdata : '0;
        end
    end

    assign cpu.ack     = cpu_ack_q;
    assign cpu.rdata   = cpu_rdata_q;
    assign video.ack   = video_ack_q;
    assign video.rdata = video_rdata_q;

    // Display priority hint, also raised while a video request waits in idle
    assign video_owns_bus = (state == arb_pkg::serving_video) ||
                            ((state == arb_pkg::idle) && video.access);

endmodule

/* source/mem_bus_if.sv */
// Access/ack bus with one access in flight; rdata is only meaningful while ack is high
`timescale 1ns/1ps

interface mem_bus_if;

    // Word address and data
    logic [mem_bus_pkg::addr_width:1]   addr;
    logic [mem_bus_pkg::data_width-1:0] wdata;
    logic [mem_bus_pkg::data_width-1:0] rdata;

    // Handshake and access qualifiers
    logic                              access;
    logic                              wr_en;
    logic [mem_bus_pkg::sel_width-1:0] bytesel;
    logic                              ack;

    // Side that starts an access and holds it until ack
    modport requester (
        output addr,
        output wdata,
        output access,
        output wr_en,
        output bytesel,
        input  rdata,
        input  ack
    );

    // Side that answers with a one-cycle ack
    modport responder (
        input  addr,
        input  wdata,
        input  access,
        input  wr_en,
        input  bytesel,
        output rdata,
        output ack
    );

endinterface

/* source/arb_pkg.sv */
// Two requesters only; state encoding is binary and never leaves idle without a pending access
package arb_pkg;

    // ====================
    // Requester identity
    // ====================

    // Also used to record which side was served last
    typedef enum logic {
        cpu   = 1'b0,
        video = 1'b1
    } requester_t;

    // ====================
    // Arbiter FSM
    // ====================

    typedef enum logic [1:0] {
        idle          = 2'd0,
        serving_cpu   = 2'd1,
        serving_video = 2'd2
    } arb_state_t;

endpackage

/* source/mem_bus_pkg.sv */
// Word-addressed 16-bit bus; the back end decodes only the low address bits and wraps above mem_words
package mem_bus_pkg;

    // ====================
    // Bus format
    // ====================

    // Word address covers byte address bits 19 down to 1
    localparam int addr_width = 19;
    localparam int data_width = 16;

    // Bit 0 selects the low byte
    localparam int sel_width = 2;

    // ====================
    // Back-end model
    // ====================

    localparam int mem_words = 4096;
    localparam int mem_index_width = $clog2(mem_words);

    // Cycles between seeing an access and raising ack
    localparam int wait_states = 2;
    localparam int wait_cnt_width = $clog2(wait_states + 1);

    typedef logic [wait_cnt_width-1:0] wait_cnt_t;

endpackage
